// ==== vlog.f ====
source/bist_pkg.sv
source/lfsr_fibonacci.sv
source/sig_misr.sv
source/bist_ctrl.sv
source/lfsr_bist.sv
bench/lfsr_bist_chk.sv
bench/lfsr_bist_tb.sv

// ==== Makefile ====
# Verilator build and run of the BIST testbench

SRCS := $(wildcard source/*.sv) $(wildcard bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vlfsr_bist_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module lfsr_bist_tb -o Vlfsr_bist_tb

# Pass only when the log holds the pass line
run: obj_dir/Vlfsr_bist_tb
	./obj_dir/Vlfsr_bist_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/lfsr_bist_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_bist_tb;

    localparam int          RUN_TIMEOUT = 5000;  // Cycles per run before giving up
    localparam logic [15:0] POLY_MODEL  = (16'h1 << 15) | (16'h1 << 14) | (16'h1 << 12)
                                          | (16'h1 << 3);  // MISR feedback bits

    logic        i_clk;
    logic        i_rst_n;  // Reset while high
    logic        i_start;
    logic [15:0] i_seed;
    logic [19:0] i_taps;
    logic [15:0] i_pat_count;
    logic [15:0] i_response;
    logic [15:0] o_pattern;
    logic        o_pat_valid;
    logic [15:0] o_signature;
    logic [15:0] o_applied;
    logic        o_busy;
    logic        o_done;
    logic        o_wrapped;

    logic [31:0] lcg_state;
    logic [15:0] exp_pat [$];  // Model pattern sequence
    logic [15:0] exp_sig;
    logic [15:0] exp_applied;
    logic        exp_wrap;
    int          checks;
    int          errors;
    bit          timed_out;

    lfsr_bist u_dut (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_start (i_start), .i_seed (i_seed),
        .i_taps (i_taps), .i_pat_count (i_pat_count), .i_response (i_response),
        .o_pattern (o_pattern), .o_pat_valid (o_pat_valid), .o_signature (o_signature),
        .o_applied (o_applied), .o_busy (o_busy), .o_done (o_done), .o_wrapped (o_wrapped)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;  // 8 ns period
    end

    ////////////////////
    // Models

    // Circuit under test, rotate left by 3 then XOR
    function automatic logic [15:0] cut_resp(input logic [15:0] p);
        return {p[12:0], p[15:13]} ^ 16'hA5C3;
    endfunction

    assign i_response = cut_resp(o_pattern);  // Same-cycle answer

    function automatic logic [15:0] tap_mask(input logic [19:0] taps);
        logic [15:0] m;
        logic [4:0]  f;
        m = '0;
        for (int i = 0; i < 4; i++) begin
            f = taps[i*5 +: 5];
            for (int j = 0; j < 16; j++) begin
                if (int'(f) == j + 1) m[j] = 1'b1;  // Field 0 and >16 tap nothing
            end
        end
        return m;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s, input logic [15:0] mask);
        return {s[14:0], ^(s & mask)};
    endfunction

    function automatic logic [15:0] misr_step(input logic [15:0] sig, input logic [15:0] d);
        return {sig[14:0], ^(sig & POLY_MODEL)} ^ d;
    endfunction

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];  // Upper bits, better spread
    endfunction

    // Whole run in software, ends on count or seed return
    task automatic build_model(input logic [15:0] seed, input logic [19:0] taps,
                               input logic [15:0] count);
        logic [15:0] s;
        logic [15:0] mask;
        logic [15:0] n;
        s = seed;
        mask = tap_mask(taps);
        n = 16'd0;
        exp_pat.delete();
        exp_sig = 16'd0;
        exp_wrap = 1'b0;
        while (1'b1) begin
            if (n == count) break;
            if (n != 16'd0 && s == seed) begin
                exp_wrap = 1'b1;  // Period seen
                break;
            end
            exp_pat.push_back(s);
            exp_sig = misr_step(exp_sig, cut_resp(s));
            s = lfsr_step(s, mask);
            n++;
        end
        exp_applied = n;
    endtask

    ////////////////////
    // Checks

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%04h, expected 0x%04h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // One test run, optional second start pulse after restart_at patterns
    task automatic run_test(input logic [15:0] seed, input logic [19:0] taps,
                            input logic [15:0] count, input int restart_at);
        int          idx;
        int          cyc;
        bit          seen_done;
        bit          restarted;
        if (timed_out) return;
        build_model(seed, taps, count);
        idx = 0;
        cyc = 0;
        seen_done = 1'b0;
        restarted = 1'b0;
        @(negedge i_clk);
        i_seed = seed;
        i_taps = taps;
        i_pat_count = count;
        i_start = 1'b1;
        while (!seen_done && cyc < RUN_TIMEOUT) begin
            @(negedge i_clk);
            i_start = 1'b0;  // Pulse ends
            cyc++;
            if (o_pat_valid) begin
                if (idx < exp_pat.size()) begin
                    check_val("o_pattern", o_pattern, exp_pat[idx]);
                end else begin
                    errors++;
                    $display("Pattern applied beyond the expected %0d", exp_pat.size());
                end
                idx++;
            end
            if (o_done) begin
                seen_done = 1'b1;
                check_val("o_applied", o_applied, exp_applied);
                check_bit("o_wrapped", o_wrapped, exp_wrap);
                check_val("o_signature", o_signature, exp_sig);
                check_bit("o_busy", o_busy, 1'b1);
                checks++;
                if (idx != exp_pat.size()) begin
                    errors++;
                    $display("Saw %0d valid patterns, model has %0d", idx, exp_pat.size());
                end
            end else if (!restarted && restart_at >= 0 && idx == restart_at) begin
                i_start = 1'b1;  // Busy, must be ignored
                restarted = 1'b1;
            end
        end
        if (!seen_done) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: o_done not seen within %0d cycles", RUN_TIMEOUT);
            return;
        end
        repeat (3) begin
            @(negedge i_clk);
            check_val("o_signature", o_signature, exp_sig);  // Held until next start
            check_val("o_applied", o_applied, exp_applied);
            check_bit("o_busy", o_busy, 1'b0);
            check_bit("o_done", o_done, 1'b0);
        end
    endtask

    ////////////////////
    // Sequence

    initial begin
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        logic [15:0] s;
        logic [19:0] taps;
        lcg_state = 32'd89;
        checks = 0;
        errors = 0;
        timed_out = 1'b0;
        i_rst_n = 1'b1;
        i_start = 1'b0;
        i_seed = 16'd0;
        i_taps = 20'd0;
        i_pat_count = 16'd0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b0;
        @(negedge i_clk);
        check_bit("o_busy", o_busy, 1'b0);  // Idle after reset
        check_bit("o_done", o_done, 1'b0);
        check_bit("o_pat_valid", o_pat_valid, 1'b0);
        check_bit("o_wrapped", o_wrapped, 1'b0);
        check_val("o_signature", o_signature, 16'd0);
        check_val("o_applied", o_applied, 16'd0);

        // Count-limited random runs
        for (int k = 0; k < 8; k++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            r3 = lcg_next();
            if (r1 == 16'd0) r1 = 16'd1;
            run_test(r1, {r2[3:0], r3}, r3 % 16'd40, -1);
        end

        // Period run, x^4+x+1 via taps 4 and 3, seed moved onto the cycle
        taps = {5'd0, 5'd0, 5'd3, 5'd4};
        s = 16'd1;
        repeat (16) s = lfsr_step(s, tap_mask(taps));
        run_test(s, taps, 16'd1000, -1);
        if (!timed_out) begin
            check_val("o_applied", o_applied, 16'd15);
            check_bit("o_wrapped", o_wrapped, 1'b1);
        end

        run_test(16'hBEEF, {5'd0, 5'd13, 5'd15, 5'd16}, 16'd0, -1);  // Zero count

        // Second start mid-run
        r1 = lcg_next();
        r2 = lcg_next();
        run_test(r1 | 16'h0001, {r2[3:0], 16'h1A2F}, 16'd30, 5);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : lfsr_bist_tb

`default_nettype wire

// ==== bench/lfsr_bist_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_bist_chk (
    input wire logic                       i_clk,
    input wire logic                       i_rst_n,
    input wire logic                       i_done,
    input wire logic                       i_busy,
    input wire logic                       i_pat_valid,
    input wire logic                       i_lfsr_load,  // High in LOAD only
    input wire logic [bist_pkg::CNT_W-1:0] i_applied,
    input wire logic [bist_pkg::CNT_W-1:0] i_pat_count
);

    ////////////////////
    // Controller properties

    // Done is a single-cycle pulse
    a_done_pulse : assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_done |=> !i_done)
        else $error("o_done high for more than one cycle");

    a_done_busy : assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_done |-> i_busy)
        else $error("o_done high while not busy");

    a_valid_busy : assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_pat_valid |-> i_busy)
        else $error("o_pat_valid high while not busy");

    // Count still holds the previous run during LOAD
    a_count_limit : assert property (@(posedge i_clk) disable iff (i_rst_n)
        (i_busy && !i_lfsr_load) |-> (i_applied <= i_pat_count))
        else $error("o_applied above i_pat_count");

endmodule : lfsr_bist_chk

bind bist_ctrl lfsr_bist_chk u_chk (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_done      (o_done),
    .i_busy      (o_busy),
    .i_pat_valid (o_pat_valid),
    .i_lfsr_load (o_lfsr_load),
    .i_applied   (o_applied),
    .i_pat_count (i_pat_count)
);

`default_nettype wire

// ==== source/lfsr_bist.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_bist (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_start,      // One-cycle start pulse
    input  wire logic [bist_pkg::PAT_W-1:0]  i_seed,       // LFSR seed, also period marker
    input  wire logic [bist_pkg::TAPS_W-1:0] i_taps,       // Packed tap fields
    input  wire logic [bist_pkg::CNT_W-1:0]  i_pat_count,  // Pattern limit
    input  wire logic [bist_pkg::PAT_W-1:0]  i_response,   // Same-cycle answer from the CUT
    output logic      [bist_pkg::PAT_W-1:0]  o_pattern,    // Stimulus to the CUT
    output logic                            o_pat_valid,
    output logic      [bist_pkg::PAT_W-1:0]  o_signature,  // Compacted responses
    output logic      [bist_pkg::CNT_W-1:0]  o_applied,
    output logic                            o_busy,
    output logic                            o_done,
    output logic                            o_wrapped
);

    logic w_lfsr_en;
    logic w_lfsr_load;
    logic w_misr_clr;
    logic w_misr_en;
    logic w_at_seed;

    ////////////////////
    // Sequencing

    bist_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pat_count (i_pat_count),
        .i_at_seed   (w_at_seed),
        .o_lfsr_en   (w_lfsr_en),
        .o_lfsr_load (w_lfsr_load),
        .o_misr_clr  (w_misr_clr),
        .o_misr_en   (w_misr_en),
        .o_pat_valid (o_pat_valid),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_wrapped   (o_wrapped),
        .o_applied   (o_applied)
    );

    ////////////////////
    // Pattern generator and compactor

    lfsr_fibonacci u_lfsr (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_en      (w_lfsr_en),
        .i_load    (w_lfsr_load),
        .i_seed    (i_seed),
        .i_taps    (i_taps),
        .o_state   (o_pattern),  // Pattern straight out
        .o_at_seed (w_at_seed)
    );

    sig_misr u_misr (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clr   (w_misr_clr),
        .i_en    (w_misr_en),
        .i_data  (i_response),
        .o_sig   (o_signature)
    );

endmodule : lfsr_bist

`default_nettype wire

// ==== source/bist_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bist_ctrl (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_start,      // One-cycle start pulse
    input  wire logic [bist_pkg::CNT_W-1:0] i_pat_count,  // Patterns to apply
    input  wire logic                      i_at_seed,    // LFSR back at seed
    output logic                           o_lfsr_en,
    output logic                           o_lfsr_load,
    output logic                           o_misr_clr,
    output logic                           o_misr_en,
    output logic                           o_pat_valid,  // Pattern applied this cycle
    output logic                           o_busy,
    output logic                           o_done,       // One-cycle done pulse
    output logic                           o_wrapped,    // Ended by seed return
    output logic      [bist_pkg::CNT_W-1:0] o_applied     // Patterns applied
);

    bist_pkg::bist_state_e r_state;
    bist_pkg::bist_state_e w_state_nxt;

    logic [bist_pkg::CNT_W-1:0] r_cnt;
    logic                       r_wrapped;
    logic                       w_end_cnt;   // Count reached
    logic                       w_end_wrap;  // Period seen
    logic                       w_apply;

    ////////////////////
    // Run decision

    // Count check covers a zero count on the first RUN cycle
    assign w_end_cnt  = (r_cnt == i_pat_count);
    // Seed match ignored before the first shift
    assign w_end_wrap = (r_cnt != '0) && i_at_seed;
    assign w_apply    = (r_state == bist_pkg::ST_RUN) && !w_end_cnt && !w_end_wrap;

    ////////////////////
    // Next state

    always_comb begin
        w_state_nxt = r_state;
        case (r_state)
            bist_pkg::ST_IDLE: if (i_start) w_state_nxt = bist_pkg::ST_LOAD;
            bist_pkg::ST_LOAD: w_state_nxt = bist_pkg::ST_RUN;
            bist_pkg::ST_RUN:  if (!w_apply) w_state_nxt = bist_pkg::ST_DONE;
            bist_pkg::ST_DONE: w_state_nxt = bist_pkg::ST_IDLE;  // Single cycle
            default:           w_state_nxt = bist_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            r_state <= bist_pkg::ST_IDLE;
        end else begin
            r_state <= w_state_nxt;  // Start while busy falls through
        end
    end

    ////////////////////
    // Counter and wrap flag

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            r_cnt     <= '0;
            r_wrapped <= 1'b0;
        end else if (r_state == bist_pkg::ST_LOAD) begin
            r_cnt     <= '0;     // New test
            r_wrapped <= 1'b0;
        end else if (w_apply) begin
            r_cnt <= r_cnt + bist_pkg::CNT_W'(1);
        end else if (r_state == bist_pkg::ST_RUN) begin
            r_wrapped <= w_end_wrap;  // Cause of the end, held after done
        end
    end

    ////////////////////
    // Outputs

    assign o_lfsr_load = (r_state == bist_pkg::ST_LOAD);
    assign o_misr_clr  = (r_state == bist_pkg::ST_LOAD);  // Clear alongside seed load
    assign o_lfsr_en   = w_apply;                         // Shift after each applied pattern
    assign o_misr_en   = w_apply;
    assign o_pat_valid = w_apply;
    assign o_busy      = (r_state != bist_pkg::ST_IDLE);
    assign o_done      = (r_state == bist_pkg::ST_DONE);
    assign o_wrapped   = r_wrapped;
    assign o_applied   = r_cnt;

endmodule : bist_ctrl

`default_nettype wire

// ==== source/sig_misr.sv ====
`timescale 1ns/1ps
`default_nettype none

module sig_misr (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_clr,   // Force zero, wins over enable
    input  wire logic                      i_en,    // Absorb i_data
    input  wire logic [bist_pkg::PAT_W-1:0] i_data,  // Circuit-under-test response
    output logic      [bist_pkg::PAT_W-1:0] o_sig    // Running signature
);

    logic [bist_pkg::PAT_W-1:0] r_sig;
    logic [bist_pkg::PAT_W-1:0] w_sig_nxt;
    logic                       w_fb;

    ////////////////////
    // Compaction step

    // Feedback from masked signature bits
    assign w_fb = ^(r_sig & bist_pkg::MISR_POLY);

    // Shift left with feedback, then fold in the response
    assign w_sig_nxt = {r_sig[bist_pkg::PAT_W-2:0], w_fb} ^ i_data;

    ////////////////////
    // Signature register

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            r_sig <= '0;
        end else if (i_clr) begin
            r_sig <= '0;         // Start of test
        end else if (i_en) begin
            r_sig <= w_sig_nxt;  // One response per applied pattern
        end
    end

    // Holds between runs, so software can read it after done
    assign o_sig = r_sig;

endmodule : sig_misr

`default_nettype wire

// ==== source/lfsr_fibonacci.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_fibonacci (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_en,     // Shift enable
    input  wire logic                       i_load,   // Seed load, wins over shift
    input  wire logic [bist_pkg::PAT_W-1:0]  i_seed,
    input  wire logic [bist_pkg::TAPS_W-1:0] i_taps,   // Packed tap fields
    output logic      [bist_pkg::PAT_W-1:0]  o_state,  // Current pattern
    output logic                            o_at_seed // Register equals seed
);

    logic [bist_pkg::PAT_W-1:0]     r_lfsr;
    logic [bist_pkg::PAT_W-1:0]     w_mask;     // Decoded tap mask
    logic [bist_pkg::TAP_IDX_W-1:0] w_field [bist_pkg::TAP_CNT];
    logic                           w_fb;       // Feedback bit

    ////////////////////
    // Tap decode

    always_comb begin
        for (int i = 0; i < bist_pkg::TAP_CNT; i++) begin
            w_field[i] = i_taps[i*bist_pkg::TAP_IDX_W +: bist_pkg::TAP_IDX_W];
        end
    end

    // Bit j tapped when any field holds j+1, zero never matches
    always_comb begin
        w_mask = '0;
        for (int j = 0; j < bist_pkg::PAT_W; j++) begin
            for (int i = 0; i < bist_pkg::TAP_CNT; i++) begin
                if (w_field[i] == bist_pkg::TAP_IDX_W'(j + 1)) begin
                    w_mask[j] = 1'b1;
                end
            end
        end
    end

    assign w_fb = ^(r_lfsr & w_mask);  // XOR of tapped bits

    ////////////////////
    // Shift register

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            r_lfsr <= '0;
        end else if (i_load) begin
            r_lfsr <= i_seed;  // Load first
        end else if (i_en) begin
            r_lfsr <= {r_lfsr[bist_pkg::PAT_W-2:0], w_fb};  // Shift left, feedback in
        end
    end

    assign o_state   = r_lfsr;
    assign o_at_seed = (r_lfsr == i_seed);  // Period marker

endmodule : lfsr_fibonacci

`default_nettype wire

// ==== source/bist_pkg.sv ====
`default_nettype none

package bist_pkg;

    ////////////////////
    // Datapath widths

    localparam int PAT_W = 16;  // LFSR, pattern, response, signature
    localparam int CNT_W = 16;  // Pattern count and applied count

    ////////////////////
    // Tap field layout

    // Field value 0 is an unused tap, value p taps LFSR bit p-1
    localparam int TAP_CNT   = 4;                    // Number of tap fields
    localparam int TAP_IDX_W = 5;                    // Bits per tap field
    localparam int TAPS_W    = TAP_CNT * TAP_IDX_W;  // Packed tap bus, field i at i*5

    ////////////////////
    // Signature register

    // Feedback mask, bits 15 14 12 3
    localparam logic [PAT_W-1:0] MISR_POLY = 16'hD008;

    ////////////////////
    // Controller states

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // Waiting for start
        ST_LOAD = 2'd1,  // Seed load, signature clear
        ST_RUN  = 2'd2,  // Apply patterns
        ST_DONE = 2'd3   // One-cycle completion
    } bist_state_e;

endpackage : bist_pkg

`default_nettype wire
